// ==== flist.f ====
+incdir+logic
logic/lsu_sched_pkg.sv
logic/lsu_issue_entry.sv
logic/lsu_issue_picker.sv
logic/lsu_replay_credits.sv
logic/lsu_issue_queue.sv
tb/lsu_issue_queue_tb.sv

// ==== logic/lsu_issue_entry.sv ====
`timescale 1ns/1ns
`include "lsu_sched_defs.svh"

module lsu_issue_entry (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic                      i_put,
  input  lsu_sched_pkg::lsu_entry_t i_put_entry,

  input  logic                      i_wr_valid,
  input  logic [`LSU_TAG_W-1:0]     i_wr_tag,

  input  logic                      i_picked,
  input  logic                      i_ex1_valid,   // Already decoded to this entry
  input  lsu_sched_pkg::lsu_haz_t   i_ex1_haz,

  input  logic                      i_tlb_resolve,
  input  logic [`LSU_ID_W-1:0]      i_head_id,
  input  logic                      i_st_idle,
  input  logic                      i_replay_full,
  input  logic                      i_flush,

  input  logic                      i_done_grant,

  output logic                      o_free,
  output logic                      o_ready,
  output lsu_sched_pkg::lsu_entry_t o_entry,
  output logic                      o_clear_req
);

  lsu_sched_pkg::lsu_sched_state_t r_state;
  lsu_sched_pkg::lsu_sched_state_t w_state_next;
  lsu_sched_pkg::lsu_entry_t       r_entry;
  lsu_sched_pkg::lsu_entry_t       w_entry_next;

  logic [`LSU_TAG_W-1:0] w_rs_tag [2];
  logic [1:0]            w_rs_hit;
  logic                  w_oldest;
  logic                  w_ops_ready;
  logic                  w_haz_release;

  // ------------------------------------------------
  // Operand wakeup
  // ------------------------------------------------
  // On a put the incoming tag is compared, so a same-cycle write counts
  for (genvar rs = 0; rs < 2; rs++) begin : g_rs
    assign w_rs_tag[rs] = i_put ? i_put_entry.rs[rs].tag : r_entry.rs[rs].tag;
    assign w_rs_hit[rs] = i_wr_valid & (w_rs_tag[rs] == i_wr_tag);
  end

  assign w_oldest    = (r_entry.id == i_head_id) & i_st_idle;
  assign w_ops_ready = lsu_sched_pkg::lsu_ops_ready(r_entry);

  always_comb begin
    case (r_entry.haz_reason)
      lsu_sched_pkg::LSU_HAZ_TLB_MISS:  w_haz_release = i_tlb_resolve;
      lsu_sched_pkg::LSU_HAZ_UC_ACCESS: w_haz_release = w_oldest;
      lsu_sched_pkg::LSU_HAZ_REPLAY:    w_haz_release = !i_replay_full;
      default:                          w_haz_release = 1'b0;
    endcase
  end

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    w_entry_next = r_entry;

    case (r_state)
      lsu_sched_pkg::LSU_SCHED_INIT: begin
        if (i_put) begin
          w_entry_next = i_put_entry;
          w_state_next = lsu_sched_pkg::LSU_SCHED_WAIT;
        end
      end
      lsu_sched_pkg::LSU_SCHED_WAIT: begin
        if (i_picked) begin
          w_state_next = lsu_sched_pkg::LSU_SCHED_ISSUED;
        end
      end
      lsu_sched_pkg::LSU_SCHED_ISSUED: begin
        if (i_ex1_valid) begin
          case (i_ex1_haz)
            lsu_sched_pkg::LSU_HAZ_NONE: begin
              w_state_next = lsu_sched_pkg::LSU_SCHED_CLEAR;
            end
            lsu_sched_pkg::LSU_HAZ_REPLAY: begin
              if (i_replay_full) begin
                w_state_next            = lsu_sched_pkg::LSU_SCHED_HAZ_WAIT;
                w_entry_next.haz_reason = lsu_sched_pkg::LSU_HAZ_REPLAY;
              end else begin
                w_state_next = lsu_sched_pkg::LSU_SCHED_CLEAR;  // Handed to replay queue
              end
            end
            default: begin
              w_state_next            = lsu_sched_pkg::LSU_SCHED_HAZ_WAIT;
              w_entry_next.haz_reason = i_ex1_haz;
            end
          endcase
        end else begin
          w_state_next = lsu_sched_pkg::LSU_SCHED_CLEAR;
        end
      end
      lsu_sched_pkg::LSU_SCHED_HAZ_WAIT: begin
        if (w_haz_release) begin
          w_state_next            = lsu_sched_pkg::LSU_SCHED_WAIT;
          w_entry_next.haz_reason = lsu_sched_pkg::LSU_HAZ_NONE;
        end
      end
      lsu_sched_pkg::LSU_SCHED_CLEAR: begin
        if (i_done_grant) begin
          w_state_next       = lsu_sched_pkg::LSU_SCHED_INIT;
          w_entry_next.valid = 1'b0;
        end
      end
      default: begin
        w_state_next = lsu_sched_pkg::LSU_SCHED_INIT;
      end
    endcase

    for (int rs = 0; rs < 2; rs++) begin
      w_entry_next.rs[rs].ready = w_entry_next.rs[rs].ready | w_rs_hit[rs];
    end

    // Flush drops the op silently
    if (i_flush) begin
      w_state_next       = lsu_sched_pkg::LSU_SCHED_INIT;
      w_entry_next.valid = 1'b0;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= lsu_sched_pkg::LSU_SCHED_INIT;
      r_entry <= '0;
    end else begin
      r_state <= w_state_next;
      r_entry <= w_entry_next;
    end
  end

  assign o_free      = (r_state == lsu_sched_pkg::LSU_SCHED_INIT);
  assign o_ready     = r_entry.valid & (r_state == lsu_sched_pkg::LSU_SCHED_WAIT) & !i_flush &
                       w_ops_ready & (!r_entry.need_oldest | w_oldest);
  assign o_entry     = r_entry;
  assign o_clear_req = (r_state == lsu_sched_pkg::LSU_SCHED_CLEAR) & !i_flush;

  // Picker and issue handshake must only select a ready entry
  a_pick_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_ready);

  a_haz_reason: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_state == lsu_sched_pkg::LSU_SCHED_HAZ_WAIT) |->
      (r_entry.haz_reason != lsu_sched_pkg::LSU_HAZ_NONE));

endmodule

// ==== logic/lsu_issue_picker.sv ====
`timescale 1ns/1ns
`include "lsu_sched_defs.svh"

module lsu_issue_picker (
  input  logic                   i_ready [`LSU_ENTRY_NUM],
  input  logic [`LSU_ID_W-1:0]   i_ids   [`LSU_ENTRY_NUM],
  input  logic                   i_free  [`LSU_ENTRY_NUM],
  input  logic [`LSU_ID_W-1:0]   i_head_id,

  output logic                   o_pick_valid,
  output logic [`LSU_IDX_W-1:0]  o_pick_idx,
  output logic                   o_alloc_valid,
  output logic [`LSU_IDX_W-1:0]  o_alloc_idx
);

  localparam int N  = `LSU_ENTRY_NUM;
  localparam int IW = `LSU_IDX_W;

  logic [`LSU_ID_W-1:0] w_age [N];
  logic [`LSU_ID_W-1:0] w_best_age;

  for (genvar e = 0; e < N; e++) begin : g_age
    assign w_age[e] = lsu_sched_pkg::lsu_age(i_ids[e], i_head_id);
  end

  // ------------------------------------------------
  // Oldest ready entry
  // ------------------------------------------------
  // Ids of live entries are distinct, so no tie to break
  always_comb begin
    o_pick_valid = 1'b0;
    o_pick_idx   = '0;
    w_best_age   = '1;
    for (int e = 0; e < N; e++) begin
      if (i_ready[e] && (!o_pick_valid || (w_age[e] < w_best_age))) begin
        o_pick_valid = 1'b1;
        o_pick_idx   = IW'(e);
        w_best_age   = w_age[e];
      end
    end
  end

  // ------------------------------------------------
  // Dispatch slot
  // ------------------------------------------------
  always_comb begin
    o_alloc_valid = 1'b0;
    o_alloc_idx   = '0;
    for (int e = N - 1; e >= 0; e--) begin  // Lowest index wins
      if (i_free[e]) begin
        o_alloc_valid = 1'b1;
        o_alloc_idx   = IW'(e);
      end
    end
  end

endmodule

// ==== logic/lsu_issue_queue.sv ====
`timescale 1ns/1ns
`include "lsu_sched_defs.svh"

module lsu_issue_queue (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic                      i_disp_valid,
  output logic                      o_disp_ready,
  input  logic [`LSU_ID_W-1:0]      i_disp_id,
  input  logic                      i_disp_rs_valid [2],
  input  logic [`LSU_TAG_W-1:0]     i_disp_rs_tag   [2],
  input  logic                      i_disp_uncached,

  input  logic                      i_wr_valid,
  input  logic [`LSU_TAG_W-1:0]     i_wr_tag,

  output logic                      o_iss_valid,
  input  logic                      i_iss_ready,
  output logic [`LSU_ID_W-1:0]      o_iss_id,
  output logic [`LSU_IDX_W-1:0]     o_iss_idx,

  input  logic                      i_ex1_valid,
  input  logic [`LSU_IDX_W-1:0]     i_ex1_idx,
  input  lsu_sched_pkg::lsu_haz_t   i_ex1_haz,

  input  logic                      i_tlb_resolve,
  input  logic [`LSU_ID_W-1:0]      i_head_id,
  input  logic                      i_st_idle,
  input  logic                      i_replay_release,
  input  logic                      i_flush,

  output logic                      o_done_valid,
  output logic [`LSU_ID_W-1:0]      o_done_id,
  output logic [`LSU_CREDIT_W-1:0]  o_replay_credits
);

  localparam int N  = `LSU_ENTRY_NUM;
  localparam int IW = `LSU_IDX_W;

  lsu_sched_pkg::lsu_entry_t w_put_entry;
  lsu_sched_pkg::lsu_entry_t w_entry [N];

  logic                 w_put        [N];
  logic                 w_picked     [N];
  logic                 w_ex1_hit    [N];
  logic                 w_ready      [N];
  logic                 w_free       [N];
  logic                 w_clear_req  [N];
  logic                 w_done_grant [N];
  logic [`LSU_ID_W-1:0] w_ids        [N];

  logic          w_pick_valid;
  logic [IW-1:0] w_pick_idx;
  logic          w_alloc_valid;
  logic [IW-1:0] w_alloc_idx;
  logic [IW-1:0] w_done_idx;
  logic          w_replay_full;
  logic          w_replay_take;
  logic          r_hold_valid;
  logic [IW-1:0] r_hold_idx;

  // ------------------------------------------------
  // Dispatch
  // ------------------------------------------------
  always_comb begin
    w_put_entry       = '0;
    w_put_entry.valid = 1'b1;
    w_put_entry.id    = i_disp_id;
    for (int rs = 0; rs < 2; rs++) begin
      w_put_entry.rs[rs].valid = i_disp_rs_valid[rs];
      w_put_entry.rs[rs].tag   = i_disp_rs_tag[rs];
    end
    w_put_entry.need_oldest = i_disp_uncached;
    w_put_entry.haz_reason  = lsu_sched_pkg::LSU_HAZ_NONE;
  end

  assign o_disp_ready = w_alloc_valid & !i_flush;

  // ------------------------------------------------
  // Issue, held steady under back-pressure
  // ------------------------------------------------
  assign o_iss_idx   = r_hold_valid ? r_hold_idx : w_pick_idx;
  assign o_iss_valid = r_hold_valid ? w_ready[r_hold_idx] : w_pick_valid;
  assign o_iss_id    = w_ids[o_iss_idx];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hold_valid <= 1'b0;
    end else begin
      r_hold_valid <= o_iss_valid & !i_iss_ready & !i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_iss_valid & !i_iss_ready) begin
      r_hold_idx <= o_iss_idx;
    end
  end

  // Done report, lowest index first
  always_comb begin
    o_done_valid = 1'b0;
    w_done_idx   = '0;
    for (int e = N - 1; e >= 0; e--) begin
      if (w_clear_req[e]) begin
        o_done_valid = 1'b1;
        w_done_idx   = IW'(e);
      end
    end
  end

  assign o_done_id     = w_ids[w_done_idx];
  assign w_replay_take = i_ex1_valid & (i_ex1_haz == lsu_sched_pkg::LSU_HAZ_REPLAY) &
                         !w_replay_full;

  for (genvar e = 0; e < N; e++) begin : g_entry
    assign w_put[e]        = i_disp_valid & o_disp_ready & (w_alloc_idx == IW'(e));
    assign w_picked[e]     = o_iss_valid & i_iss_ready & (o_iss_idx == IW'(e));
    assign w_ex1_hit[e]    = i_ex1_valid & (i_ex1_idx == IW'(e));
    assign w_done_grant[e] = o_done_valid & (w_done_idx == IW'(e));
    assign w_ids[e]        = w_entry[e].id;

    lsu_issue_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_put         (w_put[e]),
      .i_put_entry   (w_put_entry),
      .i_wr_valid    (i_wr_valid),
      .i_wr_tag      (i_wr_tag),
      .i_picked      (w_picked[e]),
      .i_ex1_valid   (w_ex1_hit[e]),
      .i_ex1_haz     (i_ex1_haz),
      .i_tlb_resolve (i_tlb_resolve),
      .i_head_id     (i_head_id),
      .i_st_idle     (i_st_idle),
      .i_replay_full (w_replay_full),
      .i_flush       (i_flush),
      .i_done_grant  (w_done_grant[e]),
      .o_free        (w_free[e]),
      .o_ready       (w_ready[e]),
      .o_entry       (w_entry[e]),
      .o_clear_req   (w_clear_req[e])
    );
  end

  lsu_issue_picker u_picker (
    .i_ready       (w_ready),
    .i_ids         (w_ids),
    .i_free        (w_free),
    .i_head_id     (i_head_id),
    .o_pick_valid  (w_pick_valid),
    .o_pick_idx    (w_pick_idx),
    .o_alloc_valid (w_alloc_valid),
    .o_alloc_idx   (w_alloc_idx)
  );

  lsu_replay_credits u_replay_credits (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_take        (w_replay_take),
    .i_release     (i_replay_release),
    .o_replay_full (w_replay_full),
    .o_credits     (o_replay_credits)
  );

endmodule

// ==== logic/lsu_replay_credits.sv ====
`timescale 1ns/1ns
`include "lsu_sched_defs.svh"

module lsu_replay_credits (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_take,
  input  logic                       i_release,

  output logic                       o_replay_full,
  output logic [`LSU_CREDIT_W-1:0]   o_credits
);

  localparam int CW = `LSU_CREDIT_W;
  localparam logic [CW-1:0] FULL_CNT = `LSU_REPLAY_SLOTS;

  logic [CW-1:0] r_count;
  logic          w_take;
  logic          w_release;

  // Both ends saturate
  assign w_take    = i_take & (r_count != '0);
  assign w_release = i_release & ((r_count != FULL_CNT) | w_take);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= FULL_CNT;  // All slots free
    end else if (w_take & !w_release) begin
      r_count <= r_count - CW'(1);
    end else if (w_release & !w_take) begin
      r_count <= r_count + CW'(1);
    end
  end

  assign o_replay_full = (r_count == '0);
  assign o_credits     = r_count;

  // The queue only takes a credit when full was low
  a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_take |-> (r_count != '0));

endmodule

// ==== logic/lsu_sched_defs.svh ====
`ifndef LSU_SCHED_DEFS_SVH
`define LSU_SCHED_DEFS_SVH

// ------------------------------------------------
// Queue sizing
// ------------------------------------------------
`define LSU_ENTRY_NUM    4

// Entry index width
`define LSU_IDX_W        ($clog2(`LSU_ENTRY_NUM))

// Physical register tag
`define LSU_TAG_W        5

// Op id, handed out in program order and wrapping
`define LSU_ID_W         6

// ------------------------------------------------
// Replay queue
// ------------------------------------------------
`define LSU_REPLAY_SLOTS 2

// Wide enough to hold a full credit count
`define LSU_CREDIT_W     ($clog2(`LSU_REPLAY_SLOTS + 1))

`endif

// ==== logic/lsu_sched_pkg.sv ====
`include "lsu_sched_defs.svh"

package lsu_sched_pkg;

  // ------------------------------------------------
  // Entry state machine
  // ------------------------------------------------
  typedef enum logic [2:0] {
    LSU_SCHED_INIT,     // Free
    LSU_SCHED_WAIT,
    LSU_SCHED_ISSUED,
    LSU_SCHED_HAZ_WAIT,
    LSU_SCHED_CLEAR
  } lsu_sched_state_t;

  // Hazard reported by the first execute stage
  typedef enum logic [1:0] {
    LSU_HAZ_NONE,
    LSU_HAZ_TLB_MISS,
    LSU_HAZ_UC_ACCESS,
    LSU_HAZ_REPLAY
  } lsu_haz_t;

  typedef struct packed {
    logic                  valid;
    logic [`LSU_TAG_W-1:0] tag;
    logic                  ready;
  } lsu_src_t;

  typedef struct packed {
    logic                 valid;
    logic [`LSU_ID_W-1:0] id;
    lsu_src_t [1:0]       rs;
    logic                 need_oldest;  // Uncached, waits to be head
    lsu_haz_t             haz_reason;
  } lsu_entry_t;

  // A missing source counts as ready
  function automatic logic lsu_ops_ready(lsu_entry_t entry);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < 2; i++) begin
      ok &= !entry.rs[i].valid | entry.rs[i].ready;
    end
    return ok;
  endfunction

  // Distance from the head, wraps with the id space
  function automatic logic [`LSU_ID_W-1:0] lsu_age(logic [`LSU_ID_W-1:0] id,
                                                    logic [`LSU_ID_W-1:0] head);
    return id - head;
  endfunction

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the issue queue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f flist.f \
  --top-module lsu_issue_queue_tb \
  -o lsu_issue_queue_sim

./obj_dir/lsu_issue_queue_sim | tee sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0

// ==== tb/lsu_issue_queue_tb.sv ====
`timescale 1ns/1ns
`include "lsu_sched_defs.svh"

module lsu_issue_queue_tb;

  localparam string DATA_FILE = "tb/lsu_testdata.txt";
  localparam int    MAX_CYC   = 512;
  localparam int    MAX_TESTS = 16;

  typedef struct packed {
    logic                  dv;
    logic [`LSU_ID_W-1:0]  id;
    logic [1:0]            rs_valid;
    logic [`LSU_TAG_W-1:0] rs0_tag;
    logic [`LSU_TAG_W-1:0] rs1_tag;
    logic                  uncached;
    logic [1:0]            haz;
    logic                  wr_valid;
    logic [`LSU_TAG_W-1:0] wr_tag;
    logic                  iss_ready;
    logic                  tlb;
    logic [`LSU_ID_W-1:0]  head;
    logic                  st_idle;
    logic                  release_slot;
    logic                  flush;
  } cycle_t;

  logic                          i_clk;
  logic                          i_reset_n;
  logic                          i_disp_valid;
  logic                          o_disp_ready;
  logic [`LSU_ID_W-1:0]          i_disp_id;
  logic                          i_disp_rs_valid [2];
  logic [`LSU_TAG_W-1:0]         i_disp_rs_tag   [2];
  logic                          i_disp_uncached;
  logic                          i_wr_valid;
  logic [`LSU_TAG_W-1:0]         i_wr_tag;
  logic                          o_iss_valid;
  logic                          i_iss_ready;
  logic [`LSU_ID_W-1:0]          o_iss_id;
  logic [`LSU_IDX_W-1:0]         o_iss_idx;
  logic                          i_ex1_valid;
  logic [`LSU_IDX_W-1:0]         i_ex1_idx;
  lsu_sched_pkg::lsu_haz_t       i_ex1_haz;
  logic                          i_tlb_resolve;
  logic [`LSU_ID_W-1:0]          i_head_id;
  logic                          i_st_idle;
  logic                          i_replay_release;
  logic                          i_flush;
  logic                          o_done_valid;
  logic [`LSU_ID_W-1:0]          o_done_id;
  logic [`LSU_CREDIT_W-1:0]      o_replay_credits;

  cycle_t stim      [MAX_CYC];
  int     check_at  [MAX_CYC + 1];
  string  test_name [MAX_TESTS];
  int     exp_credits [MAX_TESTS];
  int     exp_issues  [MAX_TESTS];
  int     exp_n       [MAX_TESTS];
  int     exp_ids     [MAX_TESTS][8];
  logic [1:0] haz_by_id [1 << `LSU_ID_W];  // First-issue hazard per op id
  logic       live_id   [1 << `LSU_ID_W];  // Accepted and not yet done or flushed

  cycle_t pending [$];   // Dispatches waiting for o_disp_ready
  int     got_ids [$];
  int     total_cyc;
  int     n_tests;
  int     cyc_idx;
  int     run_cycles;
  int     cycle_limit;
  int     errors;
  int     checks;
  int     issues;
  int     stalls;
  int     credits_seen;
  int     live_cnt;
  logic                  exp_disp_ready;
  logic                  iss_fire;
  logic [`LSU_ID_W-1:0]  iss_fire_id;
  logic [`LSU_IDX_W-1:0] iss_fire_idx;

  lsu_issue_queue u_lsu_issue_queue (.*);

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  // --------------------------------------------------
  // Load the data file and expand repeated cycles
  // --------------------------------------------------
  initial begin
    int     fd;
    string  line;
    string  tname;
    int     v [17];
    int     e [11];
    cycle_t c;

    i_reset_n          = 1'b0;
    i_disp_valid       = 1'b0;
    i_disp_id          = '0;
    i_disp_uncached    = 1'b0;
    i_disp_rs_valid[0] = 1'b0;
    i_disp_rs_valid[1] = 1'b0;
    i_disp_rs_tag[0]   = '0;
    i_disp_rs_tag[1]   = '0;
    i_wr_valid         = 1'b0;
    i_wr_tag           = '0;
    i_iss_ready        = 1'b0;
    i_ex1_valid        = 1'b0;
    i_ex1_idx          = '0;
    i_ex1_haz          = lsu_sched_pkg::LSU_HAZ_NONE;
    i_tlb_resolve      = 1'b0;
    i_head_id          = '0;
    i_st_idle          = 1'b1;
    i_replay_release   = 1'b0;
    i_flush            = 1'b0;
    total_cyc      = 0;
    n_tests        = 0;
    cyc_idx        = 0;
    run_cycles     = 0;
    cycle_limit    = MAX_CYC + 58;
    errors         = 0;
    checks         = 0;
    issues         = 0;
    stalls         = 0;
    credits_seen   = 0;
    live_cnt       = 0;
    exp_disp_ready = 1'b1;
    iss_fire       = 1'b0;
    iss_fire_id    = '0;
    iss_fire_idx   = '0;
    for (int i = 0; i <= MAX_CYC; i++) check_at[i] = -1;
    for (int i = 0; i < (1 << `LSU_ID_W); i++) begin
      haz_by_id[i] = 2'd0;
      live_id[i]   = 1'b0;
    end

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", DATA_FILE);
      $display("Something failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0) continue;
        if (line.getc(0) == "T") begin
          void'($sscanf(line, "T %s", tname));
          test_name[n_tests] = tname;
        end else if (line.getc(0) == "C") begin
          void'($sscanf(line, "C %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15], v[16]));
          for (int r = 0; r < v[0]; r++) begin
            c.dv           = (r == 0) && (v[1] != 0);  // Dispatch only once per line
            c.id           = `LSU_ID_W'(v[2]);
            c.rs_valid     = {v[5] != 0, v[3] != 0};
            c.rs0_tag      = `LSU_TAG_W'(v[4]);
            c.rs1_tag      = `LSU_TAG_W'(v[6]);
            c.uncached     = v[7] != 0;
            c.haz          = 2'(v[8]);
            c.wr_valid     = v[9] != 0;
            c.wr_tag       = `LSU_TAG_W'(v[10]);
            c.iss_ready    = v[11] != 0;
            c.tlb          = v[12] != 0;
            c.head         = `LSU_ID_W'(v[13]);
            c.st_idle      = v[14] != 0;
            c.release_slot = (r == 0) && (v[15] != 0);
            c.flush        = v[16] != 0;
            stim[total_cyc] = c;
            total_cyc++;
          end
        end else if (line.getc(0) == "E") begin
          for (int i = 0; i < 11; i++) e[i] = 0;
          void'($sscanf(line, "E %d %d %d %d %d %d %d %d %d %d %d",
                        e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7], e[8], e[9], e[10]));
          exp_credits[n_tests] = e[0];
          exp_issues[n_tests]  = e[1];
          exp_n[n_tests]       = e[2];
          for (int i = 0; i < 8; i++) exp_ids[n_tests][i] = e[3 + i];
          check_at[total_cyc] = n_tests;
          n_tests++;
        end
      end
      $fclose(fd);
      cycle_limit = total_cyc + 8 + 50;
      repeat (8) @(posedge i_clk);
      i_reset_n <= 1'b1;
    end
  end

  // --------------------------------------------------
  // Monitor sampled mid-cycle
  // --------------------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      // A slot is free unless every entry holds an accepted op
      exp_disp_ready = (live_cnt < `LSU_ENTRY_NUM) && !i_flush;
      checks++;
      assert (o_disp_ready == exp_disp_ready) else begin
        $display("MISMATCH t=%0t o_disp_ready got %0b expected %0b",
                 $time, o_disp_ready, exp_disp_ready);
        errors++;
      end
      if (o_done_valid) begin
        got_ids.push_back(int'(o_done_id));
        checks++;
        assert (live_id[o_done_id]) else begin
          $display("done report at %0t for id %0d, which is not in the queue",
                   $time, o_done_id);
          errors++;
        end
        if (live_id[o_done_id]) begin
          live_cnt--;
        end
        live_id[o_done_id] = 1'b0;
      end
      iss_fire     = o_iss_valid & i_iss_ready;
      iss_fire_id  = o_iss_id;
      iss_fire_idx = o_iss_idx;
      if (iss_fire) begin
        issues++;
        checks++;
        assert (live_id[o_iss_id]) else begin
          $display("issue at %0t of id %0d, which is not in the queue", $time, o_iss_id);
          errors++;
        end
      end
      if (i_disp_valid && o_disp_ready) begin
        pending.delete(0);
        live_id[i_disp_id] = 1'b1;
        live_cnt++;
      end
      if (i_disp_valid && !o_disp_ready) stalls++;
      if (i_flush) begin
        for (int i = 0; i < (1 << `LSU_ID_W); i++) live_id[i] = 1'b0;
        live_cnt = 0;
      end
      credits_seen = int'(o_replay_credits);
    end
  end

  task automatic check_test(input int t);
    int errs_before;
    errs_before = errors;
    assert (got_ids.size() == exp_n[t]) else begin
      $display("test %0d: %0d done reports, expected %0d", t, got_ids.size(), exp_n[t]);
      errors++;
    end
    for (int i = 0; i < exp_n[t] && i < got_ids.size(); i++) begin
      checks++;
      assert (got_ids[i] == exp_ids[t][i]) else begin
        $display("MISMATCH t=%0t o_done_id[%0d] got %0d expected %0d",
                 $time, i, got_ids[i], exp_ids[t][i]);
        errors++;
      end
    end
    assert (credits_seen == exp_credits[t]) else begin
      $display("MISMATCH t=%0t o_replay_credits got %0d expected %0d",
               $time, credits_seen, exp_credits[t]);
      errors++;
    end
    assert (issues == exp_issues[t]) else begin
      $display("test %0d: %0d issue transfers, expected %0d", t, issues, exp_issues[t]);
      errors++;
    end
    assert (pending.size() == 0) else begin
      $display("test %0d: a dispatch was never accepted", t);
      errors++;
    end
    checks += 4;
    $display("test %0d %-12s %s  done=%0d issues=%0d disp_stalls=%0d", t, test_name[t],
             (errors == errs_before) ? "pass" : "FAIL", got_ids.size(), issues, stalls);
    got_ids.delete();
    issues = 0;
    stalls = 0;
  endtask

  // --------------------------------------------------
  // Stimulus player and feedback
  // --------------------------------------------------
  always @(posedge i_clk) begin
    cycle_t s;
    if (i_reset_n) begin
      if (check_at[cyc_idx] >= 0) check_test(check_at[cyc_idx]);
      if (cyc_idx == total_cyc) begin
        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
          $display("Everything OK");
        end else begin
          $display("Something failed");
        end
        $finish;
      end else begin
        s = stim[cyc_idx];
        if (s.dv) begin
          pending.push_back(s);
          haz_by_id[s.id] = s.haz;
        end
        i_disp_valid <= (pending.size() != 0);
        if (pending.size() != 0) begin
          i_disp_id          <= pending[0].id;
          i_disp_rs_valid[0] <= pending[0].rs_valid[0];
          i_disp_rs_valid[1] <= pending[0].rs_valid[1];
          i_disp_rs_tag[0]   <= pending[0].rs0_tag;
          i_disp_rs_tag[1]   <= pending[0].rs1_tag;
          i_disp_uncached    <= pending[0].uncached;
        end
        i_wr_valid       <= s.wr_valid;
        i_wr_tag         <= s.wr_tag;
        i_iss_ready      <= s.iss_ready;
        i_tlb_resolve    <= s.tlb;
        i_head_id        <= s.head;
        i_st_idle        <= s.st_idle;
        i_replay_release <= s.release_slot;
        i_flush          <= s.flush;
        // Feedback one cycle after each issue transfer
        i_ex1_valid <= iss_fire;
        i_ex1_idx   <= iss_fire_idx;
        i_ex1_haz   <= lsu_sched_pkg::lsu_haz_t'(haz_by_id[iss_fire_id]);
        if (iss_fire) haz_by_id[iss_fire_id] = 2'd0;  // Re-issue runs clean
        cyc_idx++;
      end
    end
  end

  always @(posedge i_clk) begin
    run_cycles++;
    if (run_cycles > cycle_limit) begin
      $display("timeout: run still going after %0d cycles", run_cycles);
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== tb/lsu_testdata.txt ====
# T name | C rep dv id r0v r0t r1v r1t uc haz wv wt rdy tlb head idle rel flush
# E credits issues n ids... (haz 0 none, 1 tlb miss, 2 uncached, 3 replay)
T age_order
C 1 1 1 0 0 0 0 0 0 0 0 0 0 1 1 0 0
C 1 1 2 0 0 0 0 0 0 0 0 0 0 1 1 0 0
C 1 1 3 0 0 0 0 0 0 0 0 0 0 1 1 0 0
C 1 1 4 0 0 0 0 0 0 0 0 0 0 1 1 0 0
C 1 1 5 0 0 0 0 0 0 0 0 0 0 1 1 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
C 10 0 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0
E 2 5 5 1 2 3 4 5
T wakeup
C 1 1 6 1 10 0 0 0 0 0 0 1 0 6 1 0 0
C 1 1 7 0 0 0 0 0 0 0 0 1 0 6 1 0 0
C 4 0 0 0 0 0 0 0 0 0 0 1 0 6 1 0 0
C 1 0 0 0 0 0 0 0 0 1 10 1 0 6 1 0 0
C 3 0 0 0 0 0 0 0 0 0 0 1 0 6 1 0 0
C 1 1 8 0 0 1 11 0 0 1 11 1 0 6 1 0 0
C 5 0 0 0 0 0 0 0 0 0 0 1 0 6 1 0 0
E 2 3 3 7 6 8
T tlb_miss
C 1 1 9 0 0 0 0 0 1 0 0 1 0 9 1 0 0
C 1 1 10 0 0 0 0 0 0 0 0 1 0 9 1 0 0
C 4 0 0 0 0 0 0 0 0 0 0 1 0 9 1 0 0
C 1 0 0 0 0 0 0 0 0 0 0 1 1 9 1 0 0
C 5 0 0 0 0 0 0 0 0 0 0 1 0 9 1 0 0
E 2 3 2 10 9
T uncached
C 1 1 12 0 0 0 0 1 0 0 0 1 0 11 0 0 0
C 1 1 13 0 0 0 0 0 0 0 0 1 0 11 0 0 0
C 4 0 0 0 0 0 0 0 0 0 0 1 0 11 0 0 0
C 2 0 0 0 0 0 0 0 0 0 0 1 0 12 0 0 0
C 4 0 0 0 0 0 0 0 0 0 0 1 0 12 1 0 0
E 2 2 2 13 12
T replay_full
C 1 1 20 0 0 0 0 0 3 0 0 1 0 20 1 0 0
C 1 1 21 0 0 0 0 0 3 0 0 1 0 20 1 0 0
C 1 1 22 0 0 0 0 0 3 0 0 1 0 20 1 0 0
C 5 0 0 0 0 0 0 0 0 0 0 1 0 20 1 0 0
C 1 0 0 0 0 0 0 0 0 0 0 1 0 20 1 1 0
C 7 0 0 0 0 0 0 0 0 0 0 1 0 20 1 0 0
E 1 4 3 20 21 22
T flush
C 1 1 30 1 5 0 0 0 0 0 0 0 0 30 1 1 0
C 1 1 31 1 5 0 0 0 0 0 0 0 0 30 1 0 0
C 1 1 32 0 0 0 0 0 0 0 0 0 0 30 1 0 0
C 2 0 0 0 0 0 0 0 0 0 0 0 0 30 1 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 0 30 1 0 1
C 1 0 0 0 0 0 0 0 0 0 0 0 0 30 1 0 0
C 1 1 33 0 0 0 0 0 0 0 0 1 0 30 1 0 0
C 4 0 0 0 0 0 0 0 0 0 0 1 0 30 1 0 0
E 2 1 1 33
